/* hw/sdram_bridge_pkg.sv */
`default_nettype none

package sdram_bridge_pkg;

	// peripheral bus fields
	typedef logic [13:0] bus_adr_t;
	// low part of adr, register inside the block
	typedef logic [8:0]  reg_off_t;
	// high part of adr, which block is addressed
	typedef logic [4:0]  blk_sel_t;
	typedef logic [7:0]  byte_t;

	// application port fields
	typedef logic [31:0] addr_t;
	// burst length in 32-bit words
	typedef logic [7:0]  len_t;
	typedef logic [7:0]  ptr_t;
	typedef logic [31:0] word_t;

	// sequencer states, also the status register value
	typedef enum logic [7:0] {
		st_idle   = 8'd0,
		st_req_wr = 8'd1,
		st_wr     = 8'd2,
		st_req_rd = 8'd3,
		st_rd     = 8'd4
	} xfer_state_t;

	// register map, byte registers
	localparam reg_off_t REG_STATUS = 9'd0;
	// request address, little endian bytes
	localparam reg_off_t REG_ADDR0  = 9'd1;
	localparam reg_off_t REG_ADDR1  = 9'd2;
	localparam reg_off_t REG_ADDR2  = 9'd3;
	localparam reg_off_t REG_ADDR3  = 9'd4;
	// bytes of the buffer word at the pointer
	localparam reg_off_t REG_DATA0  = 9'd5;
	localparam reg_off_t REG_DATA1  = 9'd6;
	localparam reg_off_t REG_DATA2  = 9'd7;
	localparam reg_off_t REG_DATA3  = 9'd8;
	localparam reg_off_t REG_PTR    = 9'd9;
	localparam reg_off_t REG_LEN    = 9'd10;
	// zero starts a write burst, anything else a read burst
	localparam reg_off_t REG_GO     = 9'd11;

endpackage

`default_nettype wire

/* hw/reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_decode #(
	parameter sdram_bridge_pkg::blk_sel_t BLOCK_SEL = 5'd1
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire sdram_bridge_pkg::bus_adr_t adr,
	input  wire                            we,
	input  wire sdram_bridge_pkg::byte_t    dat_w,
	output logic [3:0]                     data_byte_we,
	output logic                           ptr_we,
	output sdram_bridge_pkg::ptr_t         ptr_wdata,
	output logic                           go,
	output logic                           go_rd,
	output logic                           rd_en,
	output sdram_bridge_pkg::reg_off_t     rd_off,
	output sdram_bridge_pkg::addr_t        req_addr,
	output sdram_bridge_pkg::len_t         req_len
);
	import sdram_bridge_pkg::*;

	blk_sel_t   blk_field;
	reg_off_t   off;
	logic       hit;
	logic       wr_acc;
	logic [3:0] addr_byte_we;
	logic       len_we;

	// split the bus address into block and register fields
	assign {blk_field, off} = adr;

	// any cycle with our block field is an access
	assign hit    = (blk_field == BLOCK_SEL);
	assign wr_acc = hit && we;

	// read side, readback_mux registers the byte
	assign rd_en  = hit && !we;
	assign rd_off = off;

	// byte strobes for the address register and the buffer word
	for (genvar i = 0; i < 4; i++) begin : g_byte_we
		assign addr_byte_we[i] = wr_acc && (off == reg_off_t'(REG_ADDR0 + i));
		assign data_byte_we[i] = wr_acc && (off == reg_off_t'(REG_DATA0 + i));
	end

	assign len_we = wr_acc && (off == REG_LEN);

	// pointer load, the sequencer ignores it while busy
	assign ptr_we    = wr_acc && (off == REG_PTR);
	assign ptr_wdata = dat_w;

	// go strobe, direction from the written byte
	assign go    = wr_acc && (off == REG_GO);
	assign go_rd = |dat_w;

	// address and length configuration
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_addr <= '0;
			req_len  <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (addr_byte_we[i]) begin
					req_addr[8*i +: 8] <= dat_w;
				end
			end
			if (len_we) begin
				req_len <= dat_w;
			end
		end
	end

endmodule

`default_nettype wire

/* hw/xfer_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module xfer_buffer #(
	parameter int BUF_DEPTH = 32
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire [3:0]                    data_byte_we,
	input  wire sdram_bridge_pkg::byte_t  dat_w,
	input  wire sdram_bridge_pkg::ptr_t   ptr,
	input  wire                          seq_we,
	input  wire sdram_bridge_pkg::word_t  seq_wdata,
	output sdram_bridge_pkg::word_t      buf_word
);
	import sdram_bridge_pkg::*;

	localparam int IDX_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;

	word_t            mem [BUF_DEPTH];
	logic [IDX_W-1:0] idx;
	logic             in_range;

	assign idx      = ptr[IDX_W-1:0];
	assign in_range = (ptr < BUF_DEPTH);

	// word at the pointer, zero when the pointer is past the end
	assign buf_word = in_range ? mem[idx] : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < BUF_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (in_range) begin
			// sequencer word write takes priority over bus bytes
			if (seq_we) begin
				mem[idx] <= seq_wdata;
			end else begin
				for (int b = 0; b < 4; b++) begin
					if (data_byte_we[b]) begin
						mem[idx][8*b +: 8] <= dat_w;
					end
				end
			end
		end
	end

	// pointer comes from the sequencer, strobes from the decoder
	// any write with the pointer off the end is lost
	a_write_in_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		(seq_we || (|data_byte_we)) |-> (ptr < BUF_DEPTH)
	);

endmodule

`default_nettype wire

/* hw/xfer_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module xfer_sequencer #(
	parameter int BUF_DEPTH = 32
) (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          go,
	input  wire                          go_rd,
	input  wire                          ptr_we,
	input  wire sdram_bridge_pkg::ptr_t   ptr_wdata,
	input  wire sdram_bridge_pkg::addr_t  req_addr,
	input  wire sdram_bridge_pkg::len_t   req_len,
	input  wire sdram_bridge_pkg::word_t  buf_word,
	input  wire                          app_req_ack,
	input  wire                          app_wr_next_req,
	input  wire sdram_bridge_pkg::word_t  app_rd_data,
	input  wire                          app_rd_valid,
	output sdram_bridge_pkg::xfer_state_t state,
	output sdram_bridge_pkg::ptr_t       ptr,
	output logic                         seq_we,
	output sdram_bridge_pkg::word_t      seq_wdata,
	output logic                         app_req,
	output logic                         app_req_wr_n,
	output sdram_bridge_pkg::addr_t      app_req_addr,
	output sdram_bridge_pkg::len_t       app_req_len,
	output sdram_bridge_pkg::word_t      app_wr_data
);
	import sdram_bridge_pkg::*;

	logic start;
	logic done;

	// go only counts while idle
	assign start = go && (state == st_idle);

	// burst complete once the pointer reaches the latched length
	assign done = (ptr >= app_req_len);

	// write data is always the buffer word at the pointer
	assign app_wr_data = buf_word;

	// read beats go straight into the buffer
	// beats past the buffer end are dropped
	assign seq_we    = (state == st_rd) && app_rd_valid && !done && (ptr < BUF_DEPTH);
	assign seq_wdata = app_rd_data;

	// request fields, held from go until the next go
	always_ff @(posedge clk) begin
		if (start) begin
			app_req_addr <= req_addr;
			app_req_len  <= req_len;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= st_idle;
			ptr          <= '0;
			app_req      <= 1'b0;
			app_req_wr_n <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					if (start) begin
						ptr          <= '0;
						app_req      <= 1'b1;
						// wr_n low selects a write burst
						app_req_wr_n <= go_rd;
						state        <= go_rd ? st_req_rd : st_req_wr;
					end else if (ptr_we) begin
						ptr <= ptr_wdata;
					end
				end
				st_req_wr, st_req_rd: begin
					// hold the request until the controller takes it
					if (app_req_ack) begin
						app_req <= 1'b0;
						state   <= (state == st_req_rd) ? st_rd : st_wr;
					end
				end
				st_wr: begin
					if (done) begin
						state <= st_idle;
					end else if (app_wr_next_req) begin
						ptr <= ptr + 1'b1;
					end
				end
				st_rd: begin
					if (done) begin
						state <= st_idle;
					end else if (app_rd_valid) begin
						ptr <= ptr + 1'b1;
					end
				end
				default: begin
					state   <= st_idle;
					app_req <= 1'b0;
				end
			endcase
		end
	end

	// request stays up until acknowledged
	a_req_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		(app_req && !app_req_ack) |=> app_req
	);

	// controller may sample the fields on any cycle of the request
	a_req_stable: assert property (
		@(posedge clk) disable iff (!rst_n)
		(app_req && !app_req_ack) |=> $stable({app_req_wr_n, app_req_addr, app_req_len})
	);

endmodule

`default_nettype wire

/* hw/readback_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               rd_en,
	input  wire sdram_bridge_pkg::reg_off_t    rd_off,
	input  wire sdram_bridge_pkg::xfer_state_t state,
	input  wire sdram_bridge_pkg::addr_t       req_addr,
	input  wire sdram_bridge_pkg::ptr_t        ptr,
	input  wire sdram_bridge_pkg::len_t        req_len,
	input  wire sdram_bridge_pkg::word_t       buf_word,
	output sdram_bridge_pkg::byte_t           dat_r
);
	import sdram_bridge_pkg::*;

	byte_t sel_byte;

	// byte behind each readable offset
	always_comb begin
		case (rd_off)
			REG_STATUS: sel_byte = byte_t'(state);
			REG_ADDR0:  sel_byte = req_addr[7:0];
			REG_ADDR1:  sel_byte = req_addr[15:8];
			REG_ADDR2:  sel_byte = req_addr[23:16];
			REG_ADDR3:  sel_byte = req_addr[31:24];
			REG_DATA0:  sel_byte = buf_word[7:0];
			REG_DATA1:  sel_byte = buf_word[15:8];
			REG_DATA2:  sel_byte = buf_word[23:16];
			REG_DATA3:  sel_byte = buf_word[31:24];
			REG_PTR:    sel_byte = ptr;
			REG_LEN:    sel_byte = req_len;
			// go and unmapped offsets read as zero
			default:    sel_byte = '0;
		endcase
	end

	// one cycle read latency, holds between reads
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dat_r <= '0;
		end else if (rd_en) begin
			dat_r <= sel_byte;
		end
	end

endmodule

`default_nettype wire

/* hw/sdram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module sdram_bridge #(
	parameter sdram_bridge_pkg::blk_sel_t BLOCK_SEL = 5'd1,
	parameter int                         BUF_DEPTH = 32
) (
	input  wire                            clk,
	input  wire                            rst_n,
	// peripheral bus
	input  wire sdram_bridge_pkg::bus_adr_t adr,
	input  wire                            we,
	input  wire sdram_bridge_pkg::byte_t    dat_w,
	output sdram_bridge_pkg::byte_t        dat_r,
	// controller application port
	output logic                           app_req,
	output logic                           app_req_wr_n,
	output sdram_bridge_pkg::addr_t        app_req_addr,
	output sdram_bridge_pkg::len_t         app_req_len,
	output sdram_bridge_pkg::word_t        app_wr_data,
	input  wire                            app_req_ack,
	input  wire                            app_wr_next_req,
	input  wire sdram_bridge_pkg::word_t    app_rd_data,
	input  wire                            app_rd_valid
);
	import sdram_bridge_pkg::*;

	// decode to buffer and sequencer
	logic [3:0]  data_byte_we;
	logic        ptr_we;
	ptr_t        ptr_wdata;
	logic        go;
	logic        go_rd;
	// decode to read-back
	logic        rd_en;
	reg_off_t    rd_off;
	addr_t       req_addr;
	len_t        req_len;
	// sequencer and buffer
	xfer_state_t state;
	ptr_t        ptr;
	logic        seq_we;
	word_t       seq_wdata;
	word_t       buf_word;

	reg_decode #(
		.BLOCK_SEL(BLOCK_SEL)
	) u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.adr(adr),
		.we(we),
		.dat_w(dat_w),
		.data_byte_we(data_byte_we),
		.ptr_we(ptr_we),
		.ptr_wdata(ptr_wdata),
		.go(go),
		.go_rd(go_rd),
		.rd_en(rd_en),
		.rd_off(rd_off),
		.req_addr(req_addr),
		.req_len(req_len)
	);

	xfer_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_buffer (
		.clk(clk),
		.rst_n(rst_n),
		.data_byte_we(data_byte_we),
		.dat_w(dat_w),
		.ptr(ptr),
		.seq_we(seq_we),
		.seq_wdata(seq_wdata),
		.buf_word(buf_word)
	);

	xfer_sequencer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.go_rd(go_rd),
		.ptr_we(ptr_we),
		.ptr_wdata(ptr_wdata),
		.req_addr(req_addr),
		.req_len(req_len),
		.buf_word(buf_word),
		.app_req_ack(app_req_ack),
		.app_wr_next_req(app_wr_next_req),
		.app_rd_data(app_rd_data),
		.app_rd_valid(app_rd_valid),
		.state(state),
		.ptr(ptr),
		.seq_we(seq_we),
		.seq_wdata(seq_wdata),
		.app_req(app_req),
		.app_req_wr_n(app_req_wr_n),
		.app_req_addr(app_req_addr),
		.app_req_len(app_req_len),
		.app_wr_data(app_wr_data)
	);

	readback_mux u_result (
		.clk(clk),
		.rst_n(rst_n),
		.rd_en(rd_en),
		.rd_off(rd_off),
		.state(state),
		.req_addr(req_addr),
		.ptr(ptr),
		.req_len(req_len),
		.buf_word(buf_word),
		.dat_r(dat_r)
	);

endmodule

`default_nettype wire

/* tb/app_ctl_model.sv */
`timescale 1ns/1ps
`default_nettype none

module app_ctl_model (
	input  wire         clk,
	input  wire         rst_n,
	// fresh random bits every cycle from the testbench
	input  wire  [31:0] rnd,
	input  wire         long_ack,
	input  wire         app_req,
	input  wire         app_req_wr_n,
	input  wire  [31:0] app_req_addr,
	input  wire  [7:0]  app_req_len,
	input  wire  [31:0] app_wr_data,
	output logic        app_req_ack,
	output logic        app_wr_next_req,
	output logic [31:0] app_rd_data,
	output logic        app_rd_valid,
	output logic        cap_wr_n,
	output logic [31:0] cap_addr,
	output logic [7:0]  cap_len,
	output int          req_count,
	output int          word_count
);
	// words seen on writes, words sent on reads
	logic [31:0] words [256];
	logic [1:0]  phase;
	int          delay;
	int          issued;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_req_ack     <= 1'b0;
			app_wr_next_req <= 1'b0;
			app_rd_data     <= '0;
			app_rd_valid    <= 1'b0;
			cap_wr_n        <= 1'b1;
			cap_addr        <= '0;
			cap_len         <= '0;
			req_count       <= 0;
			word_count      <= 0;
			phase           <= 2'd0;
			delay           <= 0;
			issued          <= 0;
		end else begin
			app_req_ack     <= 1'b0;
			app_wr_next_req <= 1'b0;
			app_rd_valid    <= 1'b0;
			// write word taken on the same edge the DUT advances
			if (app_wr_next_req) begin
				words[word_count[7:0]] <= app_wr_data;
				word_count             <= word_count + 1;
			end
			case (phase)
				2'd0: begin
					// new request, ack still high means the old one
					if (app_req && !app_req_ack) begin
						cap_wr_n   <= app_req_wr_n;
						cap_addr   <= app_req_addr;
						cap_len    <= app_req_len;
						req_count  <= req_count + 1;
						word_count <= 0;
						issued     <= 0;
						delay      <= long_ack ? 40 : int'(rnd[2:0]);
						phase      <= 2'd1;
					end
				end
				2'd1: begin
					if (delay == 0) begin
						app_req_ack <= 1'b1;
						phase       <= 2'd2;
					end else begin
						delay <= delay - 1;
					end
				end
				default: begin
					if (issued >= int'(cap_len)) begin
						phase <= 2'd0;
					end else if (rnd[3]) begin
						// wr_n high is a read burst
						if (cap_wr_n) begin
							app_rd_valid           <= 1'b1;
							app_rd_data            <= rnd;
							words[issued[7:0]]     <= rnd;
							word_count             <= word_count + 1;
						end else begin
							app_wr_next_req <= 1'b1;
						end
						issued <= issued + 1;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* tb/tb_sdram_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_bridge;
	import sdram_bridge_pkg::*;

	localparam blk_sel_t BLK        = 5'd1;
	localparam blk_sel_t OTHER_BLK  = 5'd2;
	localparam bus_adr_t IDLE_ADR   = '0;
	localparam int       DEPTH      = 32;
	localparam int       MAX_CYCLES = 20000;

	logic        clk;
	logic        rst_n;
	bus_adr_t    adr;
	logic        we;
	byte_t       dat_w;
	byte_t       dat_r;
	logic        app_req;
	logic        app_req_wr_n;
	addr_t       app_req_addr;
	len_t        app_req_len;
	word_t       app_wr_data;
	logic        app_req_ack;
	logic        app_wr_next_req;
	word_t       app_rd_data;
	logic        app_rd_valid;
	logic [31:0] rnd;
	logic        long_ack;
	logic        cap_wr_n;
	addr_t       cap_addr;
	len_t        cap_len;
	int          req_count;
	int          word_count;
	logic [15:0] lfsr = 16'd10079;
	int          cycles = 0;
	// expected register state
	addr_t       sh_addr;
	len_t        sh_len;
	ptr_t        sh_ptr;
	xfer_state_t sh_state;
	word_t       sh_buf [DEPTH];

	sdram_bridge #(.BLOCK_SEL(BLK), .BUF_DEPTH(DEPTH)) DUT (
		.clk(clk), .rst_n(rst_n), .adr(adr), .we(we), .dat_w(dat_w), .dat_r(dat_r),
		.app_req(app_req), .app_req_wr_n(app_req_wr_n), .app_req_addr(app_req_addr),
		.app_req_len(app_req_len), .app_wr_data(app_wr_data), .app_req_ack(app_req_ack),
		.app_wr_next_req(app_wr_next_req), .app_rd_data(app_rd_data),
		.app_rd_valid(app_rd_valid)
	);

	app_ctl_model u_model (
		.clk(clk), .rst_n(rst_n), .rnd(rnd), .long_ack(long_ack),
		.app_req(app_req), .app_req_wr_n(app_req_wr_n), .app_req_addr(app_req_addr),
		.app_req_len(app_req_len), .app_wr_data(app_wr_data), .app_req_ack(app_req_ack),
		.app_wr_next_req(app_wr_next_req), .app_rd_data(app_rd_data),
		.app_rd_valid(app_rd_valid), .cap_wr_n(cap_wr_n), .cap_addr(cap_addr),
		.cap_len(cap_len), .req_count(req_count), .word_count(word_count)
	);

	always #4 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step per bit taken
	function logic [31:0] get_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// expected read-back byte from the shadow registers
	function automatic byte_t expect_reg(input reg_off_t off);
		word_t w;
		w = (sh_ptr < DEPTH) ? sh_buf[sh_ptr[4:0]] : '0;
		case (off)
			REG_STATUS: return byte_t'(sh_state);
			REG_ADDR0:  return sh_addr[7:0];
			REG_ADDR1:  return sh_addr[15:8];
			REG_ADDR2:  return sh_addr[23:16];
			REG_ADDR3:  return sh_addr[31:24];
			REG_DATA0:  return w[7:0];
			REG_DATA1:  return w[15:8];
			REG_DATA2:  return w[23:16];
			REG_DATA3:  return w[31:24];
			REG_PTR:    return sh_ptr;
			REG_LEN:    return sh_len;
			default:    return '0;
		endcase
	endfunction

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	task automatic write_reg(input blk_sel_t blk, input reg_off_t off, input byte_t val);
		@(posedge clk);
		adr   <= {blk, off};
		we    <= 1'b1;
		dat_w <= val;
		@(posedge clk);
		adr <= IDLE_ADR;
		we  <= 1'b0;
		#1;
	endtask

	// dat_r is valid one edge after the access
	task automatic read_reg(input blk_sel_t blk, input reg_off_t off, output byte_t val);
		@(posedge clk);
		adr <= {blk, off};
		we  <= 1'b0;
		@(posedge clk);
		adr <= IDLE_ADR;
		#1 val = dat_r;
	endtask

	task automatic check_reg(input reg_off_t off, input string name);
		byte_t v;
		read_reg(BLK, off, v);
		check_byte(name, v, expect_reg(off));
	endtask

	task automatic check_config();
		check_reg(REG_STATUS, "status");
		check_reg(REG_ADDR0, "addr0");
		check_reg(REG_ADDR1, "addr1");
		check_reg(REG_ADDR2, "addr2");
		check_reg(REG_ADDR3, "addr3");
		check_reg(REG_PTR, "ptr");
		check_reg(REG_LEN, "len");
	endtask

	task automatic set_ptr(input ptr_t p);
		write_reg(BLK, REG_PTR, p);
		sh_ptr = p;
	endtask

	task automatic check_all_words();
		for (int w = 0; w < DEPTH; w++) begin
			set_ptr(ptr_t'(w));
			check_reg(REG_DATA0, $sformatf("word %0d byte 0", w));
			check_reg(REG_DATA1, $sformatf("word %0d byte 1", w));
			check_reg(REG_DATA2, $sformatf("word %0d byte 2", w));
			check_reg(REG_DATA3, $sformatf("word %0d byte 3", w));
		end
	endtask

	task automatic set_config(input addr_t a, input len_t l);
		for (int b = 0; b < 4; b++) begin
			write_reg(BLK, reg_off_t'(REG_ADDR0 + b), a[8*b +: 8]);
		end
		write_reg(BLK, REG_LEN, l);
		sh_addr = a;
		sh_len  = l;
	endtask

	// poll status until the sequencer is back in idle
	task automatic wait_idle();
		byte_t s;
		s = 8'hff;
		while (s != 8'd0) begin
			read_reg(BLK, REG_STATUS, s);
		end
		sh_state = st_idle;
	endtask

	always @(posedge clk) begin
		rnd    <= get_bits(32);
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$fatal(1);
		end
	end

	initial begin
		int    n0;
		len_t  l;
		addr_t old_addr;
		byte_t v;
		clk      = 1'b0;
		rst_n    = 1'b0;
		adr      = IDLE_ADR;
		we       = 1'b0;
		dat_w    = '0;
		rnd      = '0;
		long_ack = 1'b0;
		sh_addr  = '0;
		sh_len   = '0;
		sh_ptr   = '0;
		sh_state = st_idle;
		for (int i = 0; i < DEPTH; i++) begin
			sh_buf[i] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;

		// reset values, then random configuration
		check_config();
		set_config(get_bits(32), len_t'(get_bits(8)));
		set_ptr(ptr_t'(get_bits(5)));
		check_config();

		// single buffer bytes at random pointers
		for (int k = 0; k < 12; k++) begin
			int b;
			set_ptr(ptr_t'(get_bits(5)));
			b = int'(get_bits(2));
			v = byte_t'(get_bits(8));
			write_reg(BLK, reg_off_t'(REG_DATA0 + b), v);
			sh_buf[sh_ptr[4:0]][8*b +: 8] = v;
		end
		check_all_words();

		// write burst streams buffer words 0 onward
		l = len_t'(1 + get_bits(5));
		set_config(get_bits(32), l);
		n0 = req_count;
		write_reg(BLK, REG_GO, 8'd0);
		wait_idle();
		check_word("request count", word_t'(req_count), word_t'(n0 + 1));
		check_byte("app_req_wr_n", byte_t'(cap_wr_n), 8'd0);
		check_addr("app_req_addr", cap_addr, sh_addr);
		check_byte("app_req_len", cap_len, sh_len);
		check_word("write word count", word_t'(word_count), word_t'(l));
		for (int i = 0; i < int'(l); i++) begin
			check_word($sformatf("write word %0d", i), u_model.words[i], sh_buf[i]);
		end
		sh_ptr = l;
		check_config();

		// read burst fills buffer words 0 onward
		l = len_t'(1 + get_bits(5));
		set_config(get_bits(32), l);
		n0 = req_count;
		write_reg(BLK, REG_GO, byte_t'(get_bits(8)) | 8'h01);
		wait_idle();
		check_word("request count", word_t'(req_count), word_t'(n0 + 1));
		check_byte("app_req_wr_n", byte_t'(cap_wr_n), 8'd1);
		check_addr("app_req_addr", cap_addr, sh_addr);
		check_word("read word count", word_t'(word_count), word_t'(l));
		for (int i = 0; i < int'(l); i++) begin
			sh_buf[i] = u_model.words[i];
		end
		sh_ptr = l;
		check_config();
		check_all_words();

		// slow acknowledge, second go while busy
		long_ack = 1'b1;
		old_addr = sh_addr;
		n0       = req_count;
		write_reg(BLK, REG_GO, 8'd0);
		sh_state = st_req_wr;
		sh_ptr   = '0;
		repeat (3) @(posedge clk);
		#1 check_byte("app_req", byte_t'(app_req), 8'd1);
		check_reg(REG_STATUS, "status");
		write_reg(BLK, REG_ADDR0, ~sh_addr[7:0]);
		sh_addr[7:0] = ~sh_addr[7:0];
		write_reg(BLK, REG_GO, 8'h01);
		check_reg(REG_STATUS, "status");
		#1 check_byte("app_req", byte_t'(app_req), 8'd1);
		wait_idle();
		long_ack = 1'b0;
		check_word("request count", word_t'(req_count), word_t'(n0 + 1));
		check_byte("app_req_wr_n", byte_t'(cap_wr_n), 8'd0);
		check_addr("captured app_req_addr", cap_addr, old_addr);
		check_addr("app_req_addr", app_req_addr, old_addr);
		sh_ptr = sh_len;
		check_config();

		// another block field is not decoded
		check_reg(REG_LEN, "len");
		write_reg(OTHER_BLK, REG_ADDR0, ~sh_addr[7:0]);
		write_reg(OTHER_BLK, REG_LEN, ~sh_len);
		write_reg(OTHER_BLK, REG_PTR, 8'd3);
		write_reg(OTHER_BLK, REG_DATA0, 8'h5a);
		write_reg(OTHER_BLK, REG_GO, 8'd0);
		read_reg(OTHER_BLK, REG_STATUS, v);
		// dat_r still holds the length read above
		check_byte("dat_r", v, sh_len);
		check_word("request count", word_t'(req_count), word_t'(n0 + 1));
		check_config();
		check_all_words();

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
hw/sdram_bridge_pkg.sv
hw/reg_decode.sv
hw/xfer_buffer.sv
hw/xfer_sequencer.sv
hw/readback_mux.sv
hw/sdram_bridge.sv
tb/app_ctl_model.sv
tb/tb_sdram_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sdram_bridge
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
